// File: run_sim.sh
#!/usr/bin/env bash
# build and run the calculator testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_calc -o tb_calc

./obj_dir/tb_calc | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: sim.f
verilog/keypad_pkg.sv
verilog/calc_pkg.sv
verilog/input_control.sv
verilog/calc_controller.sv
verilog/calc_top.sv
test/keypad_model.sv
test/tb_calc.sv

// File: test/keypad_model.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_model (
    input  keypad_pkg::key_lines_t col_out,   // scanner columns, low = driven
    input  logic                   pressed,   // one key held down
    input  keypad_pkg::key_pos_t   key_pos,   // row * 4 + column of that key
    output keypad_pkg::key_lines_t row_in     // pulled-up rows back to the DUT
);
    import keypad_pkg::*;

    logic [1:0] key_row;
    logic [1:0] key_col;

    assign key_row = key_pos[3:2];             // upper bits pick the row
    assign key_col = key_pos[1:0];             // lower bits pick the column

    // switch closes row to column, so a row only goes low
    // while its key is down and that column is being driven low
    always_comb begin
        row_in = '1;                           // pull-ups
        if (pressed && !col_out[key_col])
            row_in[key_row] = 1'b0;            // contact shorts row to column
    end

endmodule

`default_nettype wire

// File: test/tb_calc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_calc;
    import keypad_pkg::*;

    localparam int NUM_TESTS = 9;

    logic clk = 1'b0;
    logic nRST;
    logic pressed;
    key_pos_t key_pos;
    key_lines_t row_in, col_out;
    logic signed [15:0] result;
    logic result_valid;

    // one row per test, hold codes: L long, G glitch
    string test_name [NUM_TESTS] = '{"add", "mul", "sub_neg", "chs_add", "wrap",
                                     "chain", "glitch", "eq_only", "eq_again"};
    string test_keys [NUM_TESTS] = '{"12+34=", "7*8=", "9-12=", "5F+3=", "250*300=",
                                     "2+3*4=", "91=", "42=", "="};
    string test_hold [NUM_TESTS] = '{"LLLLLL", "LLLL", "LLLLL", "LLLLL", "LLLLLLLL",
                                     "LLLLLL", "GLL", "LLL", "L"};
    logic [15:0] exp_result [NUM_TESTS] = '{16'd46, 16'd56, 16'hFFFD, 16'hFFFE, 16'd9464,
                                            16'd20, 16'd1, 16'd42, 16'd0};

    int error_count = 0;
    int pass_count = 0;
    int fail_count = 0;
    int valid_total = 0;          // result_valid pulses seen so far
    logic [15:0] last_result;     // result captured with the last pulse
    int cycle_count = 0;
    int timeout_limit = 0;

    calc_top #(
        .DEBOUNCE_CYCLES(6),
        .OPERAND_WIDTH  (16)
    ) i_calc_top (
        .clk         (clk),
        .nRST        (nRST),
        .row_in      (row_in),
        .col_out     (col_out),
        .result      (result),
        .result_valid(result_valid)
    );

    keypad_model i_keypad_model (
        .col_out(col_out),
        .pressed(pressed),
        .key_pos(key_pos),
        .row_in (row_in)
    );

    always #4 clk = ~clk;         // 8 ns period

    // outputs sampled at the rising edge, before the DUT updates
    always @(posedge clk) begin
        if (result_valid) begin
            valid_total <= valid_total + 1;
            last_result <= result;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // keypad layout: 1 2 3 + / 4 5 6 - / 7 8 9 * / = 0 . F
    function automatic key_pos_t key_to_pos(input byte c);
        case (c)
            "1": return 4'd0;
            "2": return 4'd1;
            "3": return 4'd2;
            "+": return 4'd3;
            "4": return 4'd4;
            "5": return 4'd5;
            "6": return 4'd6;
            "-": return 4'd7;
            "7": return 4'd8;
            "8": return 4'd9;
            "9": return 4'd10;
            "*": return 4'd11;
            "=": return 4'd12;
            "0": return 4'd13;
            "F": return 4'd15;    // change sign
            default: return 4'd14;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s expected 0x%h actual 0x%h", name, expected, actual);
            error_count++;
        end
    endtask

    // press on the falling edge, hold, then release for 20 cycles
    task automatic press_key(input byte c, input byte hold);
        int n;
        n = (hold == "G") ? 3 : 30;           // glitch shorter than debounce
        @(negedge clk);
        key_pos = key_to_pos(c);
        pressed = 1'b1;
        repeat (n) @(negedge clk);
        pressed = 1'b0;
        repeat (20) @(negedge clk);
    endtask

    task automatic run_test(input int t);
        int start_total;
        int waited;
        int err_before;
        err_before  = error_count;
        start_total = valid_total;
        for (int k = 0; k < test_keys[t].len(); k++)
            press_key(test_keys[t].getc(k), test_hold[t].getc(k));
        waited = 0;
        while (valid_total == start_total && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (valid_total == start_total) begin
            $display("test %s: result_valid never came after equals", test_name[t]);
            error_count++;
        end else begin
            check_value(test_name[t], {16'h0, exp_result[t]}, {16'h0, last_result});
            check_value({test_name[t], " pulses"}, 32'd1, valid_total - start_total);
        end
        if (error_count == err_before) begin
            pass_count++;
            $display("test %s ok", test_name[t]);
        end else begin
            fail_count++;
            $display("test %s failed", test_name[t]);
        end
    endtask

    initial begin
        int keys_total;
        int err_before;
        nRST    = 1'b0;
        pressed = 1'b0;
        key_pos = '0;
        keys_total = 0;
        for (int t = 0; t < NUM_TESTS; t++)
            keys_total += test_keys[t].len();
        timeout_limit = 2 * keys_total * 50;

        err_before = error_count;
        repeat (3) @(negedge clk);
        check_value("reset result_valid", 32'd0, {31'h0, result_valid});
        check_value("reset result", 32'd0, {16'h0, result});
        check_value("reset col_out", 32'hE, {28'h0, col_out});   // column 0 low
        @(negedge clk);
        nRST = 1'b1;                          // 4 cycles in reset
        @(negedge clk);
        check_value("scan one column low", 32'd1, {31'h0, $onehot(~col_out)});
        if (error_count == err_before) begin
            pass_count++;
            $display("test reset ok");
        end else begin
            fail_count++;
            $display("test reset failed");
        end

        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);

        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/calc_controller.sv
`timescale 1ns/1ps
`default_nettype none

module calc_controller #(
    parameter int OPERAND_WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            nRST,
    input  logic                            read_input,
    output logic                            key_read,     // one-cycle pulse
    input  calc_pkg::key_token_t            key_token,
    output logic signed [OPERAND_WIDTH-1:0] result,
    output logic                            result_valid
);
    import calc_pkg::*;

    localparam logic [OPERAND_WIDTH-1:0] ten = OPERAND_WIDTH'(10);

    key_token_t tok_q;                       // token taken with key_read
    logic [OPERAND_WIDTH-1:0] acc;           // entry being typed
    logic [OPERAND_WIDTH-1:0] operand;       // left side of pending op
    logic [OPERAND_WIDTH-1:0] resolved;
    op_t pend_op;

    // pulse once per offered token
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_read <= 1'b0;
        end else begin
            key_read <= read_input && !key_read;
        end
    end

    always_ff @(posedge clk) begin
        if (read_input && !key_read)
            tok_q <= key_token;                 // input_control still holds it here
    end

    // left to right with one op in flight and wrap mod 2^W
    always_comb begin
        case (pend_op)
            op_add:  resolved = operand + acc;
            op_sub:  resolved = operand - acc;
            op_mul:  resolved = operand * acc;
            default: resolved = acc;            // nothing pending
        endcase
    end

    // tok_q is valid exactly while key_read is high
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            acc          <= '0;
            operand      <= '0;
            pend_op      <= op_none;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (key_read) begin
                if (tok_q.is_digit) begin
                    acc <= acc * ten + OPERAND_WIDTH'(tok_q.digit);  // shift in decimal
                end else if (tok_q.is_op) begin
                    if (tok_q.op == op_neg) begin
                        acc <= -acc;            // two's complement
                    end else begin
                        operand <= resolved;
                        pend_op <= tok_q.op;
                        acc     <= '0;
                    end
                end else if (tok_q.is_equal) begin
                    result       <= $signed(resolved);
                    result_valid <= 1'b1;
                    operand      <= '0;
                    pend_op      <= op_none;
                    acc          <= '0;         // a second equals gives 0
                end
            end
        end
    end

    // offer withdrawn right after the take
    a_token_once: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !read_input);

    a_valid_after_equal: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |-> $past(key_read && key_token.is_equal));

endmodule

`default_nettype wire

// File: verilog/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // operator codes as seen on the token bus
    typedef enum logic [2:0] {
        op_none = 3'd0,
        op_neg  = 3'd1,    // change sign of the current entry
        op_add  = 3'd2,
        op_sub  = 3'd3,
        op_mul  = 3'd4
    } op_t;

    // one decoded key, exactly one flag set when offered
    typedef struct packed {
        logic       is_digit;
        logic       is_op;
        logic       is_equal;
        logic [3:0] digit;    // 0 .. 9, only with is_digit
        op_t        op;       // only with is_op
    } key_token_t;

endpackage

`default_nettype wire

// File: verilog/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top #(
    parameter int DEBOUNCE_CYCLES = 10,
    parameter int OPERAND_WIDTH   = 16
) (
    input  logic                            clk,
    input  logic                            nRST,
    input  keypad_pkg::key_lines_t          row_in,
    output keypad_pkg::key_lines_t          col_out,
    output logic signed [OPERAND_WIDTH-1:0] result,
    output logic                            result_valid
);
    import calc_pkg::*;

    logic read_input;        // token offered
    logic key_read;          // token taken
    key_token_t key_token;

    input_control #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_input_control (
        .clk       (clk),
        .nRST      (nRST),
        .row_in    (row_in),
        .col_out   (col_out),
        .read_input(read_input),
        .key_read  (key_read),
        .key_token (key_token)
    );

    calc_controller #(
        .OPERAND_WIDTH(OPERAND_WIDTH)
    ) i_calc_controller (
        .clk         (clk),
        .nRST        (nRST),
        .read_input  (read_input),
        .key_read    (key_read),
        .key_token   (key_token),
        .result      (result),
        .result_valid(result_valid)
    );

endmodule

`default_nettype wire

// File: verilog/input_control.sv
`timescale 1ns/1ps
`default_nettype none

module input_control #(
    parameter int DEBOUNCE_CYCLES = 10
) (
    input  logic                   clk,
    input  logic                   nRST,
    input  keypad_pkg::key_lines_t row_in,     // pulled up and low on press
    output keypad_pkg::key_lines_t col_out,    // one column low at a time
    output logic                   read_input,
    input  logic                   key_read,
    output calc_pkg::key_token_t   key_token
);
    import keypad_pkg::*;
    import calc_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    scan_state_t state_q, state_d;

    key_lines_t row_mid, row_sync;     // two-stage synchronizer
    logic [1:0] col_index;             // column being driven low
    logic [1:0] col_d1, col_d2;        // column that row_sync belongs to
    logic [CNT_W-1:0] db_cnt;
    logic key_valid;
    logic aligned;
    logic db_done;
    key_pos_t cur_pos;

    // lowest low row wins
    function automatic key_pos_t encode_key(key_lines_t rows, logic [1:0] col);
        key_pos_t pos;
        pos = pos_empty;                            // nothing low -> empty key
        for (int r = 3; r >= 0; r--) begin
            if (!rows[r]) pos = key_pos_t'({2'(r), col});
        end
        return pos;
    endfunction

    // key position to token
    function automatic key_token_t decode_key(key_pos_t pos);
        key_token_t tok;
        tok = '0;
        tok.op = op_none;
        case (pos)
            4'h0: begin tok.is_digit = 1'b1; tok.digit = 4'd1; end
            4'h1: begin tok.is_digit = 1'b1; tok.digit = 4'd2; end
            4'h2: begin tok.is_digit = 1'b1; tok.digit = 4'd3; end
            4'h3: begin tok.is_op = 1'b1; tok.op = op_add; end
            4'h4: begin tok.is_digit = 1'b1; tok.digit = 4'd4; end
            4'h5: begin tok.is_digit = 1'b1; tok.digit = 4'd5; end
            4'h6: begin tok.is_digit = 1'b1; tok.digit = 4'd6; end
            4'h7: begin tok.is_op = 1'b1; tok.op = op_sub; end
            4'h8: begin tok.is_digit = 1'b1; tok.digit = 4'd7; end
            4'h9: begin tok.is_digit = 1'b1; tok.digit = 4'd8; end
            4'hA: begin tok.is_digit = 1'b1; tok.digit = 4'd9; end
            4'hB: begin tok.is_op = 1'b1; tok.op = op_mul; end
            4'hC: tok.is_equal = 1'b1;
            4'hD: begin tok.is_digit = 1'b1; tok.digit = 4'd0; end
            4'hF: begin tok.is_op = 1'b1; tok.op = op_neg; end
            default: ;                                  // 14 never offered
        endcase
        return tok;
    endfunction

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_mid  <= '1;                             // idle keypad reads high
            row_sync <= '1;
            col_d1   <= 2'd0;
            col_d2   <= 2'd0;
        end else begin
            row_mid  <= row_in;
            row_sync <= row_mid;
            col_d1   <= col_index;                      // delay matches the row path
            col_d2   <= col_d1;
        end
    end

    always_comb begin
        col_out = '1;
        col_out[col_index] = 1'b0;
    end

    assign key_valid = ~&row_sync;                      // any row low
    assign aligned   = (col_d2 == col_index);           // rows reflect held column
    assign db_done   = (db_cnt == CNT_W'(DEBOUNCE_CYCLES));
    assign cur_pos   = encode_key(row_sync, col_index);

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle:     state_d = scan_col;
            scan_col: state_d = key_valid ? wait_stable : scan_col;
            wait_stable: begin
                if (aligned && !key_valid) state_d = idle;          // dropped out
                else if (aligned && db_done) state_d = confirm;
            end
            confirm: begin
                if (!read_input)
                    state_d = (cur_pos == pos_empty) ? wait_release : confirm;
                else if (key_read)
                    state_d = wait_release;
            end
            wait_release: state_d = (aligned && !key_valid) ? idle : wait_release;
            default: state_d = idle;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state_q    <= idle;
            col_index  <= 2'd0;
            db_cnt     <= '0;
            read_input <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == scan_col)
                col_index <= key_valid ? col_d2 : col_index + 2'd1;  // back to hit column
            if (state_q != wait_stable)
                db_cnt <= '0;
            else if (aligned)
                db_cnt <= (key_valid && !db_done) ? db_cnt + CNT_W'(1) : '0;
            if (state_q == confirm) begin
                if (!read_input)
                    read_input <= (cur_pos != pos_empty);
                else if (key_read)
                    read_input <= 1'b0;                 // falls with key_read
            end
        end
    end

    // token payload captured on the first confirm cycle
    always_ff @(posedge clk) begin
        if (state_q == confirm && !read_input)
            key_token <= decode_key(cur_pos);
    end

    // low column steps up by one while scanning
    a_col_advance: assert property (@(posedge clk) disable iff (!nRST)
        state_q == scan_col && !key_valid |=> col_out == $past({col_out[2:0], col_out[3]}));

    a_hold_until_read: assert property (@(posedge clk) disable iff (!nRST)
        read_input && !key_read |=> read_input && state_q == confirm);

    a_one_flag: assert property (@(posedge clk) disable iff (!nRST)
        read_input |-> $onehot({key_token.is_digit, key_token.is_op, key_token.is_equal}));

endmodule

`default_nettype wire

// File: verilog/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    // one line per row or column, low means active
    typedef logic [3:0] key_lines_t;

    // row * 4 + column, 0 .. 15
    typedef logic [3:0] key_pos_t;

    // position with no key printed on it
    localparam key_pos_t pos_empty = 4'hE;

    // scanner FSM
    typedef enum logic [2:0] {
        idle,           // one cycle before scanning restarts
        scan_col,       // walk the low column
        wait_stable,    // debounce the press
        confirm,        // offer token, hold until key_read
        wait_release    // block until all rows high again
    } scan_state_t;

endpackage

`default_nettype wire
